// File: logic/vrf_lane_pkg.sv
// Lane-level sizes, field types and the structs that carry commands,
// results and bank accesses through the VRF access path
`default_nettype none

package vrf_lane_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ElenBits    = 64;
  localparam int unsigned StrbBits    = ElenBits / 8;
  localparam int unsigned NrVInsn     = 4;
  localparam int unsigned NrVRegs     = 32;
  localparam int unsigned WordsPerReg = 8;
  localparam int unsigned NrOpQueues  = 2;

  // Row field sized for the default four banks
  localparam int unsigned RowBits = 6;

  //////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ElenBits-1:0]                      elen_t;
  typedef logic [StrbBits-1:0]                      strb_t;
  typedef logic [$clog2(NrVInsn)-1:0]               vid_t;
  typedef logic [$clog2(NrVRegs*WordsPerReg)-1:0]   vaddr_t;
  typedef logic [$clog2(NrVRegs)-1:0]               vreg_t;
  typedef logic [$clog2(WordsPerReg)-1:0]           vstart_t;
  // One extra bit so that a full register (8 words) fits
  typedef logic [$clog2(WordsPerReg):0]             vlen_t;
  typedef logic [RowBits-1:0]                       row_t;

  typedef enum logic {
    OPQ_A,
    OPQ_B
  } opqueue_e;

  //////////////////////////////////////////////////////////////////////
  // Commands, results and bank accesses
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vid_t               id;
    vreg_t              vs;
    vstart_t            vstart;
    vlen_t              len;
    logic [NrVInsn-1:0] hazard;
  } read_cmd_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } wb_req_t;

  typedef struct packed {
    elen_t wdata;
    strb_t be;
  } wr_view_t;

  // Reads only carry the target queue in the low bit
  typedef struct packed {
    logic [ElenBits+StrbBits-2:0] pad;
    opqueue_e                     tag;
  } rd_view_t;

  // Decoded by wen: write data or read tag
  typedef union packed {
    wr_view_t wr;
    rd_view_t rd;
  } vrf_payload_u;

  typedef struct packed {
    logic         req;
    logic         wen;
    row_t         row;
    vrf_payload_u payload;
  } vrf_port_t;

  typedef struct packed {
    logic         wen;
    row_t         row;
    vrf_payload_u payload;
  } bank_req_t;

endpackage

`default_nettype wire

// File: logic/result_writeback.sv
// Result write-back from the ALU and the load unit. Load results pass
// a one-entry stream register, both units bid for the bank given by
// the result address, and granted IDs are reported a cycle later
`timescale 1ns/1ns
`default_nettype none

module result_writeback #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // ALU port
  input  vrf_lane_pkg::wb_req_t                 alu_wb_i,
  input  logic                                  alu_req_i,
  output logic                                  alu_gnt_o,
  // Load unit port
  input  vrf_lane_pkg::wb_req_t                 ldu_wb_i,
  input  logic                                  ldu_req_i,
  output logic                                  ldu_gnt_o,
  output logic                                  ldu_final_gnt_o,
  // Bids to the bank arbiters, index 0 is the ALU, 1 the load unit
  output vrf_lane_pkg::bank_req_t [1:0]         wb_bid_o,
  output logic [1:0][NrBanks-1:0]               wb_bank_req_o,
  input  logic [1:0][NrBanks-1:0]               wb_bank_gnt_i,
  // IDs that wrote a result in the previous cycle
  output logic [vrf_lane_pkg::NrVInsn-1:0]      written_o
);

  localparam int unsigned BankBits = $clog2(NrBanks);

  //////////////////////////////////////////////////////////////////////
  // Load unit stream register
  //////////////////////////////////////////////////////////////////////

  vrf_lane_pkg::wb_req_t ldu_q;
  logic                  ldu_valid_q;
  logic                  ldu_drain;

  // Free when empty or when the held result goes to its bank now
  assign ldu_gnt_o = !ldu_valid_q || ldu_drain;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q <= 1'b0;
    end else if (ldu_gnt_o) begin
      ldu_valid_q <= ldu_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_req_i && ldu_gnt_o) begin
      ldu_q <= ldu_wb_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write bids and grants
  //////////////////////////////////////////////////////////////////////

  vrf_lane_pkg::wb_req_t [1:0] unit_wb;
  logic [1:0]                  unit_req;
  logic [1:0]                  unit_gnt;

  assign unit_wb  = {ldu_q, alu_wb_i};
  assign unit_req = {ldu_valid_q, alu_req_i};

  always_comb begin
    for (int u = 0; u < 2; u++) begin
      wb_bid_o[u].wen              = 1'b1;
      wb_bid_o[u].row              = vrf_lane_pkg::row_t'(unit_wb[u].addr >> BankBits);
      wb_bid_o[u].payload.wr.wdata = unit_wb[u].wdata;
      wb_bid_o[u].payload.wr.be    = unit_wb[u].be;
      // Low address bits pick the bank
      wb_bank_req_o[u]                                 = '0;
      wb_bank_req_o[u][unit_wb[u].addr[BankBits-1:0]]  = unit_req[u];
      unit_gnt[u]                                      = |wb_bank_gnt_i[u];
    end
  end

  assign alu_gnt_o = unit_gnt[0];
  assign ldu_drain = unit_gnt[1];

  // Result-written vector for the hazard stall
  logic [vrf_lane_pkg::NrVInsn-1:0] written_d;

  always_comb begin
    written_d = '0;
    for (int u = 0; u < 2; u++) begin
      if (unit_gnt[u]) begin
        written_d[unit_wb[u].id] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_o       <= '0;
      ldu_final_gnt_o <= 1'b0;
    end else begin
      written_o       <= written_d;
      ldu_final_gnt_o <= ldu_drain;
    end
  end

endmodule

`default_nettype wire

// File: logic/operand_requester.sv
// Operand requester for one operand queue. Walks the VRF words of a
// read command in order, one bank bid per cycle, limited by queue
// credits and stalled on read-after-write hazards
`timescale 1ns/1ns
`default_nettype none

module operand_requester #(
  parameter int unsigned NrBanks    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  vrf_lane_pkg::opqueue_e                queue_i,
  // Read commands
  input  vrf_lane_pkg::read_cmd_t               cmd_i,
  input  logic                                  cmd_valid_i,
  output logic                                  cmd_ready_o,
  // One returned queue slot per cycle
  input  logic                                  credit_i,
  input  logic [vrf_lane_pkg::NrVInsn-1:0]      written_i,
  // Bank arbiters
  output vrf_lane_pkg::bank_req_t               bid_o,
  output logic [NrBanks-1:0]                    bank_req_o,
  input  logic [NrBanks-1:0]                    bank_gnt_i
);

  localparam int unsigned BankBits   = $clog2(NrBanks);
  localparam int unsigned CreditBits = $clog2(QueueDepth + 1);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e                           state_q, state_d;
  vrf_lane_pkg::vaddr_t             addr_q, addr_d;
  vrf_lane_pkg::vlen_t              len_q, len_d;
  logic [vrf_lane_pkg::NrVInsn-1:0] hazard_q, hazard_d;
  logic [CreditBits-1:0]            credit_q, credit_d;

  logic stall;
  logic rd_req;
  logic rd_gnt;
  logic last_gnt;
  logic accept;

  //////////////////////////////////////////////////////////////////////
  // Bid
  //////////////////////////////////////////////////////////////////////

  // Every hazard ID must have written in the previous cycle
  assign stall  = |(hazard_q & ~written_i);
  assign rd_req = (state_q == REQUESTING) && !stall && (credit_q != '0);
  assign rd_gnt = |bank_gnt_i;

  always_comb begin
    bank_req_o                       = '0;
    bank_req_o[addr_q[BankBits-1:0]] = rd_req;
    bid_o.wen                        = 1'b0;
    bid_o.row                        = vrf_lane_pkg::row_t'(addr_q >> BankBits);
    bid_o.payload.rd.pad             = '0;
    bid_o.payload.rd.tag             = queue_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Command walk
  //////////////////////////////////////////////////////////////////////

  // The last grant frees the requester in the same cycle
  assign last_gnt    = rd_gnt && (len_q == vrf_lane_pkg::vlen_t'(1));
  assign cmd_ready_o = (state_q == IDLE) || last_gnt;
  assign accept      = cmd_valid_i && cmd_ready_o;

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    len_d    = len_q;
    hazard_d = hazard_q;

    if (rd_gnt) begin
      addr_d = addr_q + 1'b1;
      len_d  = len_q - 1'b1;
    end

    if (last_gnt) begin
      state_d = IDLE;
    end

    if (accept) begin
      state_d  = REQUESTING;
      // Register vs starts at word vs * WordsPerReg
      addr_d   = vrf_lane_pkg::vaddr_t'(cmd_i.vs * vrf_lane_pkg::WordsPerReg + cmd_i.vstart);
      len_d    = cmd_i.len;
      hazard_d = cmd_i.hazard;
    end
  end

  // Credits track free slots in the operand queue
  always_comb begin
    credit_d = credit_q;
    if (credit_i) begin
      credit_d = credit_d + 1'b1;
    end
    if (rd_gnt) begin
      credit_d = credit_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      len_q    <= '0;
      hazard_q <= '0;
      credit_q <= CreditBits'(QueueDepth);
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
      credit_q <= credit_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/vrf_bank_arbiter.sv
// Arbiter for one VRF bank. Two classes of two masters each, round
// robin inside a class, and the high class always masks the low one
`timescale 1ns/1ns
`default_nettype none

module vrf_bank_arbiter #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // High class, 0 is queue A and 1 the ALU
  input  vrf_lane_pkg::bank_req_t [1:0]         hi_bid_i,
  input  logic [1:0]                            hi_req_i,
  output logic [1:0]                            hi_gnt_o,
  // Low class, 0 is queue B and 1 the load unit
  input  vrf_lane_pkg::bank_req_t [1:0]         lo_bid_i,
  input  logic [1:0]                            lo_req_i,
  output logic [1:0]                            lo_gnt_o,
  // Bank port, always accepted
  output vrf_lane_pkg::vrf_port_t               port_o
);

  // Rows that exist in one bank
  localparam int unsigned RowBits = $bits(vrf_lane_pkg::vaddr_t) - $clog2(NrBanks);
  localparam vrf_lane_pkg::row_t RowMask = vrf_lane_pkg::row_t'((1 << RowBits) - 1);

  // Class 0 is high, class 1 is low
  vrf_lane_pkg::bank_req_t [1:0][1:0] cls_bid;
  logic [1:0][1:0]                    cls_req;
  logic [1:0][1:0]                    cls_gnt;
  logic [1:0]                         cls_en;
  logic [1:0]                         cls_any;
  logic [1:0]                         cls_win;
  logic [1:0]                         prio_q;
  logic                               win_cls;
  vrf_lane_pkg::bank_req_t            win_bid;

  assign cls_bid = {lo_bid_i, hi_bid_i};
  assign cls_req = {lo_req_i, hi_req_i};
  assign cls_en  = {~|hi_req_i, 1'b1};

  //////////////////////////////////////////////////////////////////////
  // Round robin per class
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      cls_any[c] = |cls_req[c];
      // Master holding the priority goes first
      cls_win[c] = cls_req[c][prio_q[c]] ? prio_q[c] : ~prio_q[c];
      cls_gnt[c] = '0;
      cls_gnt[c][cls_win[c]] = cls_en[c] && cls_any[c];
    end
  end

  assign hi_gnt_o = cls_gnt[0];
  assign lo_gnt_o = cls_gnt[1];

  // Pass priority to the other master after a grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (cls_en[c] && cls_any[c]) begin
          prio_q[c] <= ~cls_win[c];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bank port
  //////////////////////////////////////////////////////////////////////

  assign win_cls = ~cls_any[0];
  assign win_bid = cls_bid[win_cls][cls_win[win_cls]];

  always_comb begin
    port_o = '0;
    if (|cls_any) begin
      port_o.req     = 1'b1;
      port_o.wen     = win_bid.wen;
      port_o.row     = win_bid.row & RowMask;
      port_o.payload = win_bid.payload;
    end
  end

endmodule

`default_nettype wire

// File: logic/vrf_access_unit.sv
// VRF access unit of one lane. Two operand requesters and the result
// write-back share NrBanks bank arbiters that drive the VRF ports
`timescale 1ns/1ns
`default_nettype none

module vrf_access_unit #(
  parameter int unsigned NrBanks    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  // Operand read commands and queue credits
  input  vrf_lane_pkg::read_cmd_t [vrf_lane_pkg::NrOpQueues-1:0]      read_cmd_i,
  input  logic [vrf_lane_pkg::NrOpQueues-1:0]                         cmd_valid_i,
  output logic [vrf_lane_pkg::NrOpQueues-1:0]                         cmd_ready_o,
  input  logic [vrf_lane_pkg::NrOpQueues-1:0]                         opq_credit_i,
  // Results
  input  vrf_lane_pkg::wb_req_t                                       alu_wb_i,
  input  logic                                                        alu_req_i,
  output logic                                                        alu_gnt_o,
  input  vrf_lane_pkg::wb_req_t                                       ldu_wb_i,
  input  logic                                                        ldu_req_i,
  output logic                                                        ldu_gnt_o,
  output logic                                                        ldu_final_gnt_o,
  // VRF bank ports
  output vrf_lane_pkg::vrf_port_t [NrBanks-1:0]                       vrf_o
);

  vrf_lane_pkg::bank_req_t [vrf_lane_pkg::NrOpQueues-1:0] opq_bid;
  logic [vrf_lane_pkg::NrOpQueues-1:0][NrBanks-1:0]       opq_bank_req;
  logic [vrf_lane_pkg::NrOpQueues-1:0][NrBanks-1:0]       opq_bank_gnt;
  vrf_lane_pkg::bank_req_t [1:0]                          wb_bid;
  logic [1:0][NrBanks-1:0]                                wb_bank_req;
  logic [1:0][NrBanks-1:0]                                wb_bank_gnt;
  logic [vrf_lane_pkg::NrVInsn-1:0]                       written;

  result_writeback #(
    .NrBanks (NrBanks)
  ) i_result_writeback (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .alu_wb_i        (alu_wb_i),
    .alu_req_i       (alu_req_i),
    .alu_gnt_o       (alu_gnt_o),
    .ldu_wb_i        (ldu_wb_i),
    .ldu_req_i       (ldu_req_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .ldu_final_gnt_o (ldu_final_gnt_o),
    .wb_bid_o        (wb_bid),
    .wb_bank_req_o   (wb_bank_req),
    .wb_bank_gnt_i   (wb_bank_gnt),
    .written_o       (written)
  );

  for (genvar q = 0; q < vrf_lane_pkg::NrOpQueues; q++) begin : gen_requester
    operand_requester #(
      .NrBanks    (NrBanks),
      .QueueDepth (QueueDepth)
    ) i_operand_requester (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .queue_i     (vrf_lane_pkg::opqueue_e'(q)),
      .cmd_i       (read_cmd_i[q]),
      .cmd_valid_i (cmd_valid_i[q]),
      .cmd_ready_o (cmd_ready_o[q]),
      .credit_i    (opq_credit_i[q]),
      .written_i   (written),
      .bid_o       (opq_bid[q]),
      .bank_req_o  (opq_bank_req[q]),
      .bank_gnt_i  (opq_bank_gnt[q])
    );
  end

  // Queue A and the ALU form the high class
  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    vrf_bank_arbiter #(
      .NrBanks (NrBanks)
    ) i_vrf_bank_arbiter (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .hi_bid_i ({wb_bid[0], opq_bid[vrf_lane_pkg::OPQ_A]}),
      .hi_req_i ({wb_bank_req[0][b], opq_bank_req[vrf_lane_pkg::OPQ_A][b]}),
      .hi_gnt_o ({wb_bank_gnt[0][b], opq_bank_gnt[vrf_lane_pkg::OPQ_A][b]}),
      .lo_bid_i ({wb_bid[1], opq_bid[vrf_lane_pkg::OPQ_B]}),
      .lo_req_i ({wb_bank_req[1][b], opq_bank_req[vrf_lane_pkg::OPQ_B][b]}),
      .lo_gnt_o ({wb_bank_gnt[1][b], opq_bank_gnt[vrf_lane_pkg::OPQ_B][b]}),
      .port_o   (vrf_o[b])
    );
  end

endmodule

`default_nettype wire

// File: sim/vrf_access_unit_asserts.sv
// Checks for one operand requester. Credits stay within the queue
// depth, no bid goes out without a credit, and a new command is only
// taken mid-walk in the cycle of the last grant
`timescale 1ns/1ns
`default_nettype none

module vrf_access_unit_asserts #(
  parameter int unsigned QueueDepth = 4
) (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic [$clog2(QueueDepth+1)-1:0] credit_cnt_i,
  input logic                            credit_i,
  input logic                            bid_i,
  input logic                            gnt_i,
  input logic                            cmd_valid_i,
  input logic                            cmd_ready_i,
  input vrf_lane_pkg::vlen_t             cmd_len_i
);

  localparam int unsigned CntBits = $clog2(QueueDepth + 1);

  // Number of failed assertions in this instance
  int fail_cnt = 0;

  // Credits and words left, counted from the port traffic alone
  logic [CntBits-1:0]  credit_left;
  vrf_lane_pkg::vlen_t words_left;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_left <= CntBits'(QueueDepth);
      words_left  <= '0;
    end else begin
      case ({credit_i, gnt_i})
        2'b10:   credit_left <= credit_left + 1'b1;
        2'b01:   credit_left <= credit_left - 1'b1;
        default: credit_left <= credit_left;
      endcase
      if (cmd_valid_i && cmd_ready_i) begin
        words_left <= cmd_len_i;
      end else if (gnt_i) begin
        words_left <= words_left - 1'b1;
      end
    end
  end

  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_i <= QueueDepth)
    else begin
      $error("credit count %0d above queue depth %0d", credit_cnt_i, QueueDepth);
      fail_cnt++;
    end

  bid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bid_i |-> credit_left != '0)
    else begin
      $error("read bid issued with no credit left");
      fail_cnt++;
    end

  accept_on_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (words_left != '0 && cmd_valid_i && cmd_ready_i) |-> (gnt_i && words_left == 1))
    else begin
      $error("command taken while a walk was still running");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: sim/tb_vrf_access_unit.sv
// Testbench for the VRF access unit. Runs a table of read, write,
// credit, hazard and contention cases and checks the bank traffic
// against the element address rule of the lane
`timescale 1ns/1ns
`default_nettype none

module tb_vrf_access_unit;

  localparam int unsigned NrBanks    = 4;
  localparam int unsigned QueueDepth = 4;
  localparam int          NumRows    = 10;
  localparam int          MaxCycles  = 40 * NumRows;

  typedef enum logic [2:0] {RD_A, RD_B, ALU_WR, LDU_WR, MIXED, DUAL, HOLD} kind_e;

  typedef struct packed {
    kind_e                 kind;
    vrf_lane_pkg::vid_t    id;
    vrf_lane_pkg::vreg_t   vs;
    vrf_lane_pkg::vstart_t vstart;
    vrf_lane_pkg::vlen_t   len;
    logic [3:0]            hazard;
    vrf_lane_pkg::elen_t   wdata;
    vrf_lane_pkg::strb_t   be;
    vrf_lane_pkg::vaddr_t  addr;
  } test_row_t;

  // One bank access seen on vrf_o
  typedef struct packed {
    int          cyc;
    int          bank;
    int          row;
    logic        tag;
    logic [63:0] data;
    logic [7:0]  be;
  } access_t;

  // kind, id, vs, vstart, len, hazard, wdata, be, addr
  localparam test_row_t Rows [NumRows] = '{
    '{RD_A,   2'd0, 5'd3,  3'd2, 4'd5, 4'b0000, 64'h0,                  8'h00, 8'h00},
    '{RD_B,   2'd1, 5'd10, 3'd0, 4'd8, 4'b0000, 64'h0,                  8'h00, 8'h00},
    '{ALU_WR, 2'd2, 5'd0,  3'd0, 4'd0, 4'b0000, 64'h0123_4567_89ab_cdef, 8'hf0, 8'h5b},
    '{LDU_WR, 2'd3, 5'd0,  3'd0, 4'd0, 4'b0000, 64'h7e3c_0000_a5a5_1111, 8'hff, 8'h22},
    '{HOLD,   2'd0, 5'd7,  3'd0, 4'd8, 4'b0000, 64'h0,                  8'h00, 8'h00},
    '{RD_A,   2'd2, 5'd1,  3'd1, 4'd1, 4'b0100, 64'h5555_aaaa_5555_aaaa, 8'h0f, 8'h40},
    '{MIXED,  2'd1, 5'd4,  3'd3, 4'd3, 4'b0000, 64'h1357_9bdf_2468_ace0, 8'h3c, 8'h13},
    '{DUAL,   2'd0, 5'd20, 3'd0, 4'd8, 4'b0000, 64'h0,                  8'h00, 8'h00},
    '{LDU_WR, 2'd1, 5'd0,  3'd0, 4'd0, 4'b0000, 64'h0f0f_3c3c_9696_c3c3, 8'h81, 8'hff},
    '{RD_B,   2'd3, 5'd31, 3'd7, 4'd1, 4'b0000, 64'h0,                  8'h00, 8'h00}
  };

  logic                                  clk_i;
  logic                                  rst_ni;
  vrf_lane_pkg::read_cmd_t [1:0]         read_cmd_i;
  logic [1:0]                            cmd_valid_i;
  logic [1:0]                            cmd_ready_o;
  logic [1:0]                            opq_credit_i;
  vrf_lane_pkg::wb_req_t                 alu_wb_i;
  logic                                  alu_req_i;
  logic                                  alu_gnt_o;
  vrf_lane_pkg::wb_req_t                 ldu_wb_i;
  logic                                  ldu_req_i;
  logic                                  ldu_gnt_o;
  logic                                  ldu_final_gnt_o;
  vrf_lane_pkg::vrf_port_t [NrBanks-1:0] vrf_o;

  integer  seed = 32'hbd27_085d;
  int      cycle = 0;
  int      err_cnt = 0;
  int      final_cnt = 0;
  int      final_cyc = 0;
  int      model_credit [2];
  logic    hold = 1'b0;
  access_t rd_log [$];
  access_t wr_log [$];

  vrf_access_unit #(
    .NrBanks    (NrBanks),
    .QueueDepth (QueueDepth)
  ) dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .read_cmd_i      (read_cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_o     (cmd_ready_o),
    .opq_credit_i    (opq_credit_i),
    .alu_wb_i        (alu_wb_i),
    .alu_req_i       (alu_req_i),
    .alu_gnt_o       (alu_gnt_o),
    .ldu_wb_i        (ldu_wb_i),
    .ldu_req_i       (ldu_req_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .ldu_final_gnt_o (ldu_final_gnt_o),
    .vrf_o           (vrf_o)
  );

  bind operand_requester vrf_access_unit_asserts #(
    .QueueDepth (QueueDepth)
  ) i_asserts (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .credit_cnt_i (credit_q),
    .credit_i     (credit_i),
    .bid_i        (|bank_req_o),
    .gnt_i        (|bank_gnt_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_i  (cmd_ready_o),
    .cmd_len_i    (cmd_i.len)
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Credit return, bank monitor and run limit
  //////////////////////////////////////////////////////////////////////

  // Random credit return that never goes past the queue depth
  always @(posedge clk_i) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    for (int q = 0; q < 2; q++) begin
      opq_credit_i[q] <= rst_ni && !hold && (model_credit[q] < QueueDepth) && rnd[q];
    end
  end

  always @(negedge clk_i) begin
    access_t acc;
    if (rst_ni) begin
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_o[b].req) begin
          acc = '{cycle, b, int'(vrf_o[b].row), vrf_o[b].payload.rd.tag,
                  vrf_o[b].payload.wr.wdata, vrf_o[b].payload.wr.be};
          if (vrf_o[b].wen) begin
            wr_log.push_back(acc);
          end else begin
            assert (model_credit[acc.tag] > 0) else begin
              $display("queue %0d read at %0t ns with no credit left", acc.tag, $time);
              err_cnt++;
            end
            model_credit[acc.tag]--;
            rd_log.push_back(acc);
          end
        end
      end
      for (int q = 0; q < 2; q++) begin
        if (opq_credit_i[q]) model_credit[q]++;
      end
      if (ldu_final_gnt_o) begin
        final_cnt++;
        final_cyc = cycle;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle++;
      if (cycle >= MaxCycles) begin
        $display("timeout: the tests did not finish within %0d cycles", MaxCycles);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (exp == act) else begin
      $display("error at %0t ns: %s expected 'h%0h, actual 'h%0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  function automatic int count_reads(input int q);
    int n;
    n = 0;
    foreach (rd_log[i]) begin
      if (rd_log[i].tag == q[0]) n++;
    end
    return n;
  endfunction

  function automatic int first_read(input int q);
    foreach (rd_log[i]) begin
      if (rd_log[i].tag == q[0]) return rd_log[i].cyc;
    end
    return MaxCycles;
  endfunction

  function automatic int write_cycle();
    return (wr_log.size() > 0) ? wr_log[0].cyc : -1;
  endfunction

  task automatic wait_reads(input int q, input int n);
    while (count_reads(q) < n) @(posedge clk_i);
  endtask

  task automatic wait_credits_full(input int q);
    while (model_credit[q] != QueueDepth) @(posedge clk_i);
  endtask

  task automatic send_read(input int q, input vrf_lane_pkg::read_cmd_t cmd);
    @(posedge clk_i);
    read_cmd_i[q]  <= cmd;
    cmd_valid_i[q] <= 1'b1;
    do @(negedge clk_i); while (!cmd_ready_o[q]);
    @(posedge clk_i);
    cmd_valid_i[q] <= 1'b0;
  endtask

  task automatic write_alu(input vrf_lane_pkg::wb_req_t wb);
    @(posedge clk_i);
    alu_wb_i  <= wb;
    alu_req_i <= 1'b1;
    do @(negedge clk_i); while (!alu_gnt_o);
    @(posedge clk_i);
    alu_req_i <= 1'b0;
  endtask

  task automatic write_ldu(input vrf_lane_pkg::wb_req_t wb);
    @(posedge clk_i);
    ldu_wb_i  <= wb;
    ldu_req_i <= 1'b1;
    do @(negedge clk_i); while (!ldu_gnt_o);
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
  endtask

  // Element n of a command sits at word vs * 8 + vstart + n
  task automatic check_reads(input int q, input vrf_lane_pkg::read_cmd_t cmd);
    int n;
    int addr;
    // Leave room for any read beyond the command length
    repeat (4) @(posedge clk_i);
    n = 0;
    foreach (rd_log[i]) begin
      if (rd_log[i].tag == q[0]) begin
        addr = int'(cmd.vs) * vrf_lane_pkg::WordsPerReg + int'(cmd.vstart) + n;
        check_value("vrf_o bank", addr % NrBanks, rd_log[i].bank);
        check_value("vrf_o.row", addr / NrBanks, rd_log[i].row);
        n++;
      end
    end
    check_value("read count", cmd.len, n);
  endtask

  task automatic check_write(input vrf_lane_pkg::wb_req_t wb);
    check_value("write count", 1, wr_log.size());
    if (wr_log.size() > 0) begin
      check_value("vrf_o bank", wb.addr % NrBanks, wr_log[0].bank);
      check_value("vrf_o.row", wb.addr / NrBanks, wr_log[0].row);
      check_value("vrf_o.payload.wr.wdata", wb.wdata, wr_log[0].data);
      check_value("vrf_o.payload.wr.be", wb.be, wr_log[0].be);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test rows
  //////////////////////////////////////////////////////////////////////

  task automatic run_row(input test_row_t r);
    vrf_lane_pkg::read_cmd_t cmd;
    vrf_lane_pkg::wb_req_t   wb;
    int                      q;
    int                      f0;
    cmd = '{id: r.id, vs: r.vs, vstart: r.vstart, len: r.len, hazard: r.hazard};
    wb  = '{id: r.id, addr: r.addr, wdata: r.wdata, be: r.be};
    q   = (r.kind == RD_B || r.kind == MIXED) ? 1 : 0;
    f0  = final_cnt;
    rd_log.delete();
    wr_log.delete();
    case (r.kind)
      RD_A, RD_B: begin
        if (r.hazard == '0) begin
          send_read(q, cmd);
          wait_reads(q, r.len);
        end else begin
          // Reads wait for a write from an ID in the hazard mask
          wait_credits_full(q);
          send_read(q, cmd);
          repeat (6) @(posedge clk_i);
          check_value("reads before hazard write", 0, count_reads(q));
          write_alu(wb);
          wait_reads(q, r.len);
          check_write(wb);
          check_value("read after hazard write", 1, first_read(q) > write_cycle());
        end
        check_reads(q, cmd);
      end
      ALU_WR: begin
        write_alu(wb);
        check_write(wb);
      end
      LDU_WR: begin
        write_ldu(wb);
        while (final_cnt == f0) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
        check_write(wb);
        check_value("ldu_final_gnt_o pulses", 1, final_cnt - f0);
        check_value("final grant after write", 1, final_cyc > write_cycle());
      end
      MIXED: begin
        wait_credits_full(q);
        @(posedge clk_i);
        read_cmd_i[q]  <= cmd;
        cmd_valid_i[q] <= 1'b1;
        // Idle queue B takes the command here, ALU bids with its first read
        @(posedge clk_i);
        cmd_valid_i[q] <= 1'b0;
        alu_wb_i       <= wb;
        alu_req_i      <= 1'b1;
        do @(negedge clk_i); while (!alu_gnt_o);
        @(posedge clk_i);
        alu_req_i <= 1'b0;
        wait_reads(q, r.len);
        check_write(wb);
        check_reads(q, cmd);
        check_value("ALU write before queue B read", 1, write_cycle() < first_read(q));
      end
      DUAL: begin
        wait_credits_full(0);
        wait_credits_full(1);
        @(posedge clk_i);
        read_cmd_i  <= {cmd, cmd};
        cmd_valid_i <= 2'b11;
        @(posedge clk_i);
        cmd_valid_i <= 2'b00;
        wait_reads(0, r.len);
        wait_reads(1, r.len);
        check_reads(0, cmd);
        check_reads(1, cmd);
      end
      HOLD: begin
        wait_credits_full(q);
        hold <= 1'b1;
        send_read(q, cmd);
        wait_reads(q, QueueDepth);
        repeat (5) @(posedge clk_i);
        check_value("reads with credits held", QueueDepth, count_reads(q));
        hold <= 1'b0;
        wait_reads(q, r.len);
        check_reads(q, cmd);
      end
      default: begin
        $display("row with an unknown kind at %0t ns", $time);
        err_cnt++;
      end
    endcase
  endtask

  initial begin
    logic [NrBanks-1:0] reqs;
    kind_e              kind;
    int                 e0;
    int                 passed;
    int                 assert_fails;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    read_cmd_i      = '0;
    cmd_valid_i     = '0;
    opq_credit_i    = '0;
    alu_wb_i        = '0;
    alu_req_i       = 1'b0;
    ldu_wb_i        = '0;
    ldu_req_i       = 1'b0;
    model_credit[0] = QueueDepth;
    model_credit[1] = QueueDepth;
    passed          = 0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    for (int b = 0; b < NrBanks; b++) begin
      reqs[b] = vrf_o[b].req;
    end
    check_value("cmd_ready_o", 2'b11, cmd_ready_o);
    check_value("vrf_o req", 0, reqs);
    check_value("alu_gnt_o", 0, alu_gnt_o);
    // Empty stream register takes a load result
    check_value("ldu_gnt_o", 1, ldu_gnt_o);
    check_value("ldu_final_gnt_o", 0, ldu_final_gnt_o);

    for (int i = 0; i < NumRows; i++) begin
      e0   = err_cnt;
      kind = Rows[i].kind;
      run_row(Rows[i]);
      if (err_cnt == e0) passed++;
      $display("test %0d %s: %s", i, kind.name(), (err_cnt == e0) ? "ok" : "mismatch");
    end

    assert_fails = dut.gen_requester[0].i_operand_requester.i_asserts.fail_cnt
                 + dut.gen_requester[1].i_operand_requester.i_asserts.fail_cnt;
    $display("%0d tests, %0d ok, %0d check errors, %0d assertion failures",
             NumRows, passed, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/vrf_lane_pkg.sv
logic/result_writeback.sv
logic/operand_requester.sv
logic/vrf_bank_arbiter.sv
logic/vrf_access_unit.sv
sim/vrf_access_unit_asserts.sv
sim/tb_vrf_access_unit.sv

// File: Bender.yml
package:
  name: vrf_access_unit

sources:
  # RTL in compile order
  - logic/vrf_lane_pkg.sv
  - logic/result_writeback.sv
  - logic/operand_requester.sv
  - logic/vrf_bank_arbiter.sv
  - logic/vrf_access_unit.sv

  # Testbench
  - target: simulation
    files:
      - sim/vrf_access_unit_asserts.sv
      - sim/tb_vrf_access_unit.sv
